/* verilog/mmu_cfg_pkg.sv */
// ####################
// MMU configuration package
// Sv32 address geometry, page table depth and TLB sizing
// ####################
`default_nettype none

package mmu_cfg_pkg;

  localparam int vaddr_w       = 32;
  localparam int paddr_w       = 34;
  localparam int page_offset_w = 12;
  localparam int vpn_slice_w   = 10;
  localparam int levels        = 2;
  localparam int vpn_w         = levels * vpn_slice_w;
  localparam int ppn_w         = paddr_w - page_offset_w;
  localparam int tlb_entries   = 8;

  typedef logic [vaddr_w-1:0]             vaddr_t;
  typedef logic [paddr_w-1:0]             paddr_t;
  typedef logic [vpn_w-1:0]               vpn_t;
  typedef logic [vpn_slice_w-1:0]         vpn_slice_t;
  typedef logic [ppn_w-1:0]               ppn_t;
  typedef logic [$clog2(tlb_entries)-1:0] tlb_idx_t;

endpackage

`default_nettype wire

/* verilog/pte_pkg.sv */
// ####################
// Page table entry package
// Sv32 PTE bit layout, privilege mode and the
// cached TLB entry format
// ####################
`default_nettype none

package pte_pkg;

  typedef logic [31:0] pte_t;

  // Sv32 PTE flag positions
  localparam int pte_v = 0;
  localparam int pte_r = 1;
  localparam int pte_w = 2;
  localparam int pte_x = 3;
  localparam int pte_u = 4;
  localparam int pte_a = 6;
  localparam int pte_d = 7;

  localparam int ppn_lsb   = 10;
  localparam int pte_bytes = 4;

  typedef enum logic {
    priv_user       = 1'b0,
    priv_supervisor = 1'b1
  } priv_e;

  // TLB entry is {ppn, r, w, u, d}
  localparam int te_d       = 0;
  localparam int te_u       = 1;
  localparam int te_w       = 2;
  localparam int te_r       = 3;
  localparam int te_ppn_lsb = 4;

  localparam int tlb_entry_w = mmu_cfg_pkg::ppn_w + te_ppn_lsb;

  typedef logic [tlb_entry_w-1:0] tlb_entry_t;

endpackage

`default_nettype wire

/* verilog/dtlb.sv */
// ####################
// Data TLB
// Fully associative, combinational lookup, round-robin
// refill and a flush that drops every entry
// ####################
`default_nettype none

module dtlb (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  logic                lookup_v_i,
  input  mmu_cfg_pkg::vpn_t   vpn_i,
  output logic                hit_o,
  input  logic                fill_v_i,
  input  pte_pkg::tlb_entry_t fill_entry_i,
  output logic                entry_v_o,
  output pte_pkg::tlb_entry_t entry_o
);

  localparam int n = mmu_cfg_pkg::tlb_entries;

  logic [n-1:0]          valid_r;
  mmu_cfg_pkg::vpn_t     tag_r  [n];
  pte_pkg::tlb_entry_t   data_r [n];
  mmu_cfg_pkg::tlb_idx_t victim_r;

  logic [n-1:0]        match;
  pte_pkg::tlb_entry_t hit_entry;

  always_comb begin
    for (int i = 0; i < n; i++) begin
      match[i] = valid_r[i] && (tag_r[i] == vpn_i);
    end
  end

  // Match vector is one-hot, so an OR reduction selects the entry
  always_comb begin
    hit_entry = '0;
    for (int i = 0; i < n; i++) begin
      if (match[i]) begin
        hit_entry = hit_entry | data_r[i];
      end
    end
  end

  assign hit_o = lookup_v_i & (|match);

  // Written entry goes straight out during a fill
  assign entry_v_o = hit_o | fill_v_i;
  assign entry_o   = fill_v_i ? fill_entry_i : hit_entry;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[victim_r] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      victim_r <= '0;
    end else if (fill_v_i) begin
      victim_r <= victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[victim_r]  <= vpn_i;
      data_r[victim_r] <= fill_entry_i;
    end
  end

  // Walker only fills after a miss, so a page is never cached twice
  assert property (@(posedge clk_i) disable iff (reset_i)
    lookup_v_i |-> $onehot0(match));

endmodule

`default_nettype wire

/* verilog/ptw_fsm.sv */
// ####################
// Page table walker FSM
// Latches one request, looks it up in the TLB, walks
// the Sv32 table on a miss and decides page faults
// ####################
`default_nettype none

module ptw_fsm (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_v_i,
  input  mmu_cfg_pkg::vaddr_t req_vaddr_i,
  input  logic                req_store_i,
  input  logic                translation_en_i,
  output logic                req_ready_o,
  output mmu_cfg_pkg::vaddr_t vaddr_o,
  output mmu_cfg_pkg::vpn_t   vpn_o,
  output logic                store_o,
  output logic                bypass_o,
  output logic                lookup_v_o,
  input  logic                hit_i,
  output logic                walk_start_o,
  output logic                level_step_o,
  input  logic                last_level_i,
  output logic                mem_req_v_o,
  input  logic                mem_resp_v_i,
  input  pte_pkg::pte_t       mem_data_i,
  output logic                fill_v_o,
  output pte_pkg::tlb_entry_t fill_entry_o,
  output logic                walk_fault_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_walk_req,
    st_walk_wait,
    st_done
  } state_e;

  state_e              state_r;
  state_e              state_n;
  mmu_cfg_pkg::vaddr_t vaddr_r;
  logic                store_r;

  logic              pte_valid, pte_read, pte_write, pte_exec;
  logic              pte_user, pte_acc, pte_dirty;
  logic              pte_leaf, pte_bad, super_misaligned, leaf_fault;
  logic              resp_seen;
  mmu_cfg_pkg::ppn_t pte_ppn;
  mmu_cfg_pkg::ppn_t fill_ppn;

  assign pte_valid = mem_data_i[pte_pkg::pte_v];
  assign pte_read  = mem_data_i[pte_pkg::pte_r];
  assign pte_write = mem_data_i[pte_pkg::pte_w];
  assign pte_exec  = mem_data_i[pte_pkg::pte_x];
  assign pte_user  = mem_data_i[pte_pkg::pte_u];
  assign pte_acc   = mem_data_i[pte_pkg::pte_a];
  assign pte_dirty = mem_data_i[pte_pkg::pte_d];
  assign pte_ppn   = mem_data_i[$bits(pte_pkg::pte_t)-1:pte_pkg::ppn_lsb];

  // Not present, or the reserved W without R encoding
  assign pte_bad  = ~pte_valid | (pte_write & ~pte_read);
  assign pte_leaf = pte_read | pte_exec;

  // Upper level leaf is a 4 MiB superpage, PPN[0] must be zero
  assign super_misaligned = ~last_level_i & (pte_ppn[mmu_cfg_pkg::vpn_slice_w-1:0] != '0);
  assign leaf_fault       = ~pte_acc | super_misaligned;

  // Superpage is cached as the 4 KiB page that was touched
  assign fill_ppn = last_level_i ? pte_ppn :
    {pte_ppn[mmu_cfg_pkg::ppn_w-1:mmu_cfg_pkg::vpn_slice_w],
     vpn_o[mmu_cfg_pkg::vpn_slice_w-1:0]};

  assign resp_seen = (state_r == st_walk_wait) & mem_resp_v_i;

  assign req_ready_o = (state_r == st_idle);
  assign vaddr_o     = vaddr_r;
  assign vpn_o       = vaddr_r[mmu_cfg_pkg::vaddr_w-1:mmu_cfg_pkg::page_offset_w];
  assign store_o     = store_r;

  assign lookup_v_o   = (state_r == st_lookup) & translation_en_i;
  assign bypass_o     = (state_r == st_lookup) & ~translation_en_i;
  assign walk_start_o = lookup_v_o & ~hit_i;
  assign mem_req_v_o  = (state_r == st_walk_req);

  assign walk_fault_o = resp_seen & (pte_bad | (pte_leaf ? leaf_fault : last_level_i));
  assign level_step_o = resp_seen & ~pte_bad & ~pte_leaf & ~last_level_i;
  assign fill_v_o     = resp_seen & ~pte_bad & pte_leaf & ~leaf_fault;

  always_comb begin
    fill_entry_o = '0;
    fill_entry_o[pte_pkg::te_ppn_lsb +: mmu_cfg_pkg::ppn_w] = fill_ppn;
    fill_entry_o[pte_pkg::te_r] = pte_read;
    fill_entry_o[pte_pkg::te_w] = pte_write;
    fill_entry_o[pte_pkg::te_u] = pte_user;
    fill_entry_o[pte_pkg::te_d] = pte_dirty;
  end

  // Hit or bypass answers from lookup, the response shows in done
  always_comb begin
    state_n = state_r;
    case (state_r)
      st_idle: begin
        if (req_v_i) begin
          state_n = st_lookup;
        end
      end
      st_lookup: begin
        state_n = walk_start_o ? st_walk_req : st_done;
      end
      st_walk_req: begin
        state_n = st_walk_wait;
      end
      st_walk_wait: begin
        if (level_step_o) begin
          state_n = st_walk_req;
        end else if (resp_seen) begin
          state_n = st_done;
        end
      end
      st_done: begin
        state_n = st_idle;
      end
      default: begin
        state_n = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_ready_o && req_v_i) begin
      vaddr_r <= req_vaddr_i;
      store_r <= req_store_i;
    end
  end

  // Memory answers only the read that the walker is waiting on
  assert property (@(posedge clk_i) disable iff (reset_i)
    mem_resp_v_i |-> state_r == st_walk_wait);

endmodule

`default_nettype wire

/* verilog/pte_addr_gen.sv */
// ####################
// PTE address generator
// Walk level counter and table base, forms the
// address of the next page table entry to read
// ####################
`default_nettype none

module pte_addr_gen (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  walk_start_i,
  input  logic                  level_step_i,
  input  mmu_cfg_pkg::ppn_t     satp_ppn_i,
  input  mmu_cfg_pkg::vpn_t     vpn_i,
  input  mmu_cfg_pkg::ppn_t     next_ppn_i,
  output mmu_cfg_pkg::paddr_t   mem_addr_o,
  output logic                  last_level_o
);

  localparam int lvl_w = $clog2(mmu_cfg_pkg::levels);

  logic [lvl_w-1:0]        level_r;
  mmu_cfg_pkg::ppn_t       base_r;
  mmu_cfg_pkg::vpn_slice_t slice;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      level_r <= lvl_w'(mmu_cfg_pkg::levels - 1);
    end else if (walk_start_i) begin
      level_r <= lvl_w'(mmu_cfg_pkg::levels - 1);
    end else if (level_step_i) begin
      level_r <= level_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (walk_start_i) begin
      base_r <= satp_ppn_i;
    end else if (level_step_i) begin
      base_r <= next_ppn_i;
    end
  end

  assign slice = vpn_i[level_r*mmu_cfg_pkg::vpn_slice_w +: mmu_cfg_pkg::vpn_slice_w];

  assign last_level_o = (level_r == '0);
  assign mem_addr_o   = {base_r, {mmu_cfg_pkg::page_offset_w{1'b0}}}
                      + mmu_cfg_pkg::paddr_t'(slice) * mmu_cfg_pkg::paddr_t'(pte_pkg::pte_bytes);

  // Walker treats a pointer at the leaf level as a fault
  assert property (@(posedge clk_i) disable iff (reset_i)
    level_step_i |-> level_r != '0);

endmodule

`default_nettype wire

/* verilog/access_check.sv */
// ####################
// Access checker
// U/S and SUM privilege rules, store W/D and load R
// checks, registered translation response
// ####################
`default_nettype none

module access_check (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                entry_v_i,
  input  pte_pkg::tlb_entry_t entry_i,
  input  logic                walk_fault_i,
  input  logic                bypass_i,
  input  mmu_cfg_pkg::vaddr_t vaddr_i,
  input  logic                store_i,
  input  pte_pkg::priv_e      priv_i,
  input  logic                sum_i,
  output logic                resp_v_o,
  output mmu_cfg_pkg::paddr_t resp_paddr_o,
  output logic                resp_fault_o
);

  mmu_cfg_pkg::ppn_t   entry_ppn;
  logic                priv_fault, write_fault, read_fault;
  logic                fault;
  logic                resp_v_n;
  mmu_cfg_pkg::paddr_t paddr_n;
  logic                resp_v_r;
  mmu_cfg_pkg::paddr_t paddr_r;
  logic                fault_r;

  assign entry_ppn = entry_i[pte_pkg::te_ppn_lsb +: mmu_cfg_pkg::ppn_w];

  // Supervisor reaches user pages only with SUM
  assign priv_fault  = (priv_i == pte_pkg::priv_user) ? ~entry_i[pte_pkg::te_u] :
                                                        (entry_i[pte_pkg::te_u] & ~sum_i);
  assign write_fault = store_i & ~(entry_i[pte_pkg::te_w] & entry_i[pte_pkg::te_d]);
  assign read_fault  = ~store_i & ~entry_i[pte_pkg::te_r];

  assign fault    = walk_fault_i | (entry_v_i & (priv_fault | write_fault | read_fault));
  assign resp_v_n = entry_v_i | walk_fault_i | bypass_i;

  always_comb begin
    if (bypass_i) begin
      paddr_n = mmu_cfg_pkg::paddr_t'(vaddr_i);
    end else if (fault) begin
      paddr_n = '0;
    end else begin
      paddr_n = {entry_ppn, vaddr_i[mmu_cfg_pkg::page_offset_w-1:0]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= resp_v_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_v_n) begin
      paddr_r <= paddr_n;
      fault_r <= fault;
    end
  end

  assign resp_v_o     = resp_v_r;
  assign resp_paddr_o = paddr_r;
  assign resp_fault_o = fault_r;

  // Hit, fill, walk fault and bypass each end a different request
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({entry_v_i, walk_fault_i, bypass_i}));

endmodule

`default_nettype wire

/* verilog/mmu_top.sv */
// ####################
// Data MMU top
// Sv32 translation unit with TLB, page table walker
// and permission checks, one request at a time
// ####################
`default_nettype none

module mmu_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_v_i,
  input  mmu_cfg_pkg::vaddr_t req_vaddr_i,
  input  logic                req_store_i,
  output logic                req_ready_o,
  input  logic                translation_en_i,
  input  pte_pkg::priv_e      priv_i,
  input  logic                sum_i,
  input  mmu_cfg_pkg::ppn_t   satp_ppn_i,
  input  logic                flush_i,
  output logic                resp_v_o,
  output mmu_cfg_pkg::paddr_t resp_paddr_o,
  output logic                resp_fault_o,
  output logic                mem_req_v_o,
  output mmu_cfg_pkg::paddr_t mem_addr_o,
  input  logic                mem_resp_v_i,
  input  pte_pkg::pte_t       mem_data_i
);

  mmu_cfg_pkg::vaddr_t vaddr;
  mmu_cfg_pkg::vpn_t   vpn;
  logic                store, bypass, lookup_v, hit;
  logic                walk_start, level_step, last_level;
  logic                fill_v, walk_fault, entry_v;
  pte_pkg::tlb_entry_t fill_entry;
  pte_pkg::tlb_entry_t entry;

  ptw_fsm u_ptw_fsm (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .req_v_i          (req_v_i),
    .req_vaddr_i      (req_vaddr_i),
    .req_store_i      (req_store_i),
    .translation_en_i (translation_en_i),
    .req_ready_o      (req_ready_o),
    .vaddr_o          (vaddr),
    .vpn_o            (vpn),
    .store_o          (store),
    .bypass_o         (bypass),
    .lookup_v_o       (lookup_v),
    .hit_i            (hit),
    .walk_start_o     (walk_start),
    .level_step_o     (level_step),
    .last_level_i     (last_level),
    .mem_req_v_o      (mem_req_v_o),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_data_i       (mem_data_i),
    .fill_v_o         (fill_v),
    .fill_entry_o     (fill_entry),
    .walk_fault_o     (walk_fault)
  );

  pte_addr_gen u_pte_addr_gen (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .walk_start_i (walk_start),
    .level_step_i (level_step),
    .satp_ppn_i   (satp_ppn_i),
    .vpn_i        (vpn),
    .next_ppn_i   (mem_data_i[$bits(pte_pkg::pte_t)-1:pte_pkg::ppn_lsb]),
    .mem_addr_o   (mem_addr_o),
    .last_level_o (last_level)
  );

  dtlb u_dtlb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .lookup_v_i   (lookup_v),
    .vpn_i        (vpn),
    .hit_o        (hit),
    .fill_v_i     (fill_v),
    .fill_entry_i (fill_entry),
    .entry_v_o    (entry_v),
    .entry_o      (entry)
  );

  access_check u_access_check (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .entry_v_i    (entry_v),
    .entry_i      (entry),
    .walk_fault_i (walk_fault),
    .bypass_i     (bypass),
    .vaddr_i      (vaddr),
    .store_i      (store),
    .priv_i       (priv_i),
    .sum_i        (sum_i),
    .resp_v_o     (resp_v_o),
    .resp_paddr_o (resp_paddr_o),
    .resp_fault_o (resp_fault_o)
  );

endmodule

`default_nettype wire

/* test/mmu_model.svh */
// ####################
// MMU reference model
// Random Sv32 page table image, expected translation,
// expected PTE read addresses, TLB residency and
// result compare tasks
// ####################
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

mmu_cfg_pkg::ppn_t       satp_ppn;
mmu_cfg_pkg::vpn_slice_t l1_idx [4];
mmu_cfg_pkg::vpn_slice_t l0_idx [4];
pte_pkg::pte_t           pt_img [mmu_cfg_pkg::paddr_t];
mmu_cfg_pkg::vpn_t       tlb_q [$];
mmu_cfg_pkg::paddr_t     walk_addr_q [$];

function automatic int unsigned rand_below(int unsigned n);
  return $unsigned($random(seed)) % n;
endfunction

function automatic mmu_cfg_pkg::paddr_t pte_addr(mmu_cfg_pkg::ppn_t base,
                                                 mmu_cfg_pkg::vpn_slice_t idx);
  return {base, 12'h000} + mmu_cfg_pkg::paddr_t'({idx, 2'b00});
endfunction

function automatic pte_pkg::pte_t read_pte(mmu_cfg_pkg::paddr_t a);
  if (pt_img.exists(a)) begin
    return pt_img[a];
  end
  return '0;
endfunction

// Mostly good leaves, with the odd invalid, reserved or pointer entry
function automatic pte_pkg::pte_t rand_pte(mmu_cfg_pkg::ppn_t ppn, bit odd_ok);
  pte_pkg::pte_t p;
  int unsigned   r;
  p = {ppn, 2'b00, 8'($random(seed))};
  r = rand_below(16);
  if (!odd_ok && r < 3) begin
    r = 3;
  end
  p[pte_pkg::pte_v] = (r != 0);
  if (r == 1) begin
    p[pte_pkg::pte_w] = 1'b1;
    p[pte_pkg::pte_r] = 1'b0;
  end else if (r == 2) begin
    p[pte_pkg::pte_r] = 1'b0;
    p[pte_pkg::pte_w] = 1'b0;
    p[pte_pkg::pte_x] = 1'b0;
  end else if (r > 2) begin
    if (!p[pte_pkg::pte_x] || p[pte_pkg::pte_w]) begin
      p[pte_pkg::pte_r] = 1'b1;
    end
    p[pte_pkg::pte_a] = (rand_below(8) != 0);
  end
  return p;
endfunction

// Four root slots hold two tables, one superpage and one wildcard
task automatic build_page_table();
  mmu_cfg_pkg::ppn_t tab;
  mmu_cfg_pkg::ppn_t hi;
  int unsigned       kind;
  satp_ppn = 22'h000321;
  for (int j = 0; j < 4; j++) begin
    l0_idx[j] = mmu_cfg_pkg::vpn_slice_t'(j * 256 + rand_below(256));
  end
  for (int k = 0; k < 4; k++) begin
    l1_idx[k] = mmu_cfg_pkg::vpn_slice_t'(k * 256 + rand_below(256));
    kind = (k < 2) ? 0 : (k == 2) ? 1 + rand_below(2) : rand_below(5);
    tab = mmu_cfg_pkg::ppn_t'(32'h400 + k);
    hi = mmu_cfg_pkg::ppn_t'($random(seed));
    hi[9:0] = (kind == 2) ? 10'(1 + rand_below(1023)) : 10'h000;
    case (kind)
      0: pt_img[pte_addr(satp_ppn, l1_idx[k])] = {tab, 10'h001};
      1, 2: pt_img[pte_addr(satp_ppn, l1_idx[k])] = rand_pte(hi, 1'b0);
      3: pt_img[pte_addr(satp_ppn, l1_idx[k])] = {hi, 10'h0fe};
      default: pt_img[pte_addr(satp_ppn, l1_idx[k])] = {tab, 10'h0c5};
    endcase
    if (kind == 0) begin
      for (int j = 0; j < 4; j++) begin
        pt_img[pte_addr(tab, l0_idx[j])] = rand_pte(mmu_cfg_pkg::ppn_t'($random(seed)), 1'b1);
      end
    end
  end
endtask

// Predicts the response and the PTE reads and tracks which pages are cached
task automatic predict(input mmu_cfg_pkg::vaddr_t va, input logic store,
                       input pte_pkg::priv_e priv, input logic sum, input logic en,
                       output mmu_cfg_pkg::paddr_t paddr, output logic fault,
                       output int reads);
  mmu_cfg_pkg::vpn_t   vpn;
  mmu_cfg_pkg::ppn_t   ppn;
  mmu_cfg_pkg::paddr_t rd_addr;
  pte_pkg::pte_t       pte;
  int                  lvl;
  int                  walk_reads;
  logic                done;
  logic                hit;
  vpn = va[31:12];
  paddr = '0;
  fault = 1'b0;
  reads = 0;
  if (!en) begin
    paddr = mmu_cfg_pkg::paddr_t'(va);
  end else begin
    hit = 1'b0;
    foreach (tlb_q[i]) begin
      if (tlb_q[i] == vpn) begin
        hit = 1'b1;
      end
    end
    ppn = satp_ppn;
    lvl = 1;
    walk_reads = 0;
    done = 1'b0;
    while (!done) begin
      rd_addr = pte_addr(ppn, vpn[lvl*10 +: 10]);
      if (!hit) begin
        walk_addr_q.push_back(rd_addr);
      end
      pte = read_pte(rd_addr);
      walk_reads++;
      ppn = pte[31:10];
      if (!pte[pte_pkg::pte_v] || (pte[pte_pkg::pte_w] && !pte[pte_pkg::pte_r])) begin
        fault = 1'b1;
        done = 1'b1;
      end else if (pte[pte_pkg::pte_r] || pte[pte_pkg::pte_x]) begin
        done = 1'b1;
      end else if (lvl == 0) begin
        fault = 1'b1;
        done = 1'b1;
      end else begin
        lvl = 0;
      end
    end
    if (!fault && (!pte[pte_pkg::pte_a] || (lvl == 1 && ppn[9:0] != '0))) begin
      fault = 1'b1;
    end else if (!fault) begin
      if (lvl == 1) begin
        ppn[9:0] = vpn[9:0];
      end
      if (!hit) begin
        tlb_q.push_back(vpn);
        if (tlb_q.size() > 8) begin
          tlb_q.pop_front();
        end
      end
      fault = (priv == pte_pkg::priv_user) ? !pte[pte_pkg::pte_u] :
                                             (pte[pte_pkg::pte_u] && !sum);
      fault = fault | (store ? !(pte[pte_pkg::pte_w] && pte[pte_pkg::pte_d]) :
                               !pte[pte_pkg::pte_r]);
      paddr = fault ? '0 : {ppn, va[11:0]};
    end
    reads = hit ? 0 : walk_reads;
  end
endtask

task automatic check_paddr(mmu_cfg_pkg::paddr_t exp, mmu_cfg_pkg::paddr_t got);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t: resp_paddr_o expected %h got %h", $time, exp, got));
  end
endtask

task automatic check_mem_addr(mmu_cfg_pkg::paddr_t exp, mmu_cfg_pkg::paddr_t got);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t: mem_addr_o expected %h got %h", $time, exp, got));
  end
endtask

task automatic check_fault(logic exp, logic got);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t: resp_fault_o expected %b got %b", $time, exp, got));
  end
endtask

task automatic check_count(string name, int exp, int got);
  if (got != exp) begin
    fail_run($sformatf("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got));
  end
endtask

`endif

/* test/tb_mmu.sv */
// ####################
// MMU testbench
// Random translation requests checked against a
// reference model, with a page table memory responder
// ####################
`default_nettype none

module tb_mmu;

  localparam int num_reqs       = 400;
  localparam int timeout_cycles = num_reqs * 40 + 100;

  logic                clk_i;
  logic                reset_i;
  logic                req_v_i;
  mmu_cfg_pkg::vaddr_t req_vaddr_i;
  logic                req_store_i;
  logic                req_ready_o;
  logic                translation_en_i;
  pte_pkg::priv_e      priv_i;
  logic                sum_i;
  mmu_cfg_pkg::ppn_t   satp_ppn_i;
  logic                flush_i;
  logic                resp_v_o;
  mmu_cfg_pkg::paddr_t resp_paddr_o;
  logic                resp_fault_o;
  logic                mem_req_v_o;
  mmu_cfg_pkg::paddr_t mem_addr_o;
  logic                mem_resp_v_i;
  pte_pkg::pte_t       mem_data_i;

  int seed;
  int cycle_cnt = 0;
  int mem_reads = 0;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped on the first error");
  endtask

  `include "mmu_model.svh"

  mmu_top dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .req_v_i          (req_v_i),
    .req_vaddr_i      (req_vaddr_i),
    .req_store_i      (req_store_i),
    .req_ready_o      (req_ready_o),
    .translation_en_i (translation_en_i),
    .priv_i           (priv_i),
    .sum_i            (sum_i),
    .satp_ppn_i       (satp_ppn_i),
    .flush_i          (flush_i),
    .resp_v_o         (resp_v_o),
    .resp_paddr_o     (resp_paddr_o),
    .resp_fault_o     (resp_fault_o),
    .mem_req_v_o      (mem_req_v_o),
    .mem_addr_o       (mem_addr_o),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_data_i       (mem_data_i)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      fail_run("timeout: the DUT did not finish all requests within the cycle limit");
    end
  end

  // Page table memory answering 1 to 4 cycles after each read
  initial begin : responder
    mmu_cfg_pkg::paddr_t req_addr;
    mmu_cfg_pkg::paddr_t exp_addr;
    int unsigned         delay;
    forever begin
      @(posedge clk_i);
      if (mem_req_v_o === 1'b1) begin
        mem_reads++;
        req_addr = mem_addr_o;
        if (walk_addr_q.size() == 0) begin
          fail_run("the DUT read a page table entry when the model expected no read");
        end
        exp_addr = walk_addr_q.pop_front();
        check_mem_addr(exp_addr, req_addr);
        delay = 1 + rand_below(4);
        repeat (delay - 1) @(posedge clk_i);
        mem_resp_v_i <= 1'b1;
        mem_data_i   <= read_pte(req_addr);
        @(posedge clk_i);
        mem_resp_v_i <= 1'b0;
      end
    end
  end

  initial begin : stimulus
    mmu_cfg_pkg::vaddr_t va;
    mmu_cfg_pkg::paddr_t exp_paddr;
    pte_pkg::priv_e      priv;
    logic                en, sum, st, exp_fault;
    int                  exp_reads, reads0, lat;
    seed = 32'hed56;
    clk_i = 1'b0;
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_vaddr_i = '0;
    req_store_i = 1'b0;
    translation_en_i = 1'b0;
    priv_i = pte_pkg::priv_supervisor;
    sum_i = 1'b0;
    flush_i = 1'b0;
    mem_resp_v_i = 1'b0;
    mem_data_i = '0;
    build_page_table();
    satp_ppn_i = satp_ppn;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    for (int n = 0; n < num_reqs; n++) begin
      if (rand_below(25) == 0) begin
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        tlb_q.delete();
      end
      en = (rand_below(8) != 0);
      priv = pte_pkg::priv_e'(rand_below(2));
      sum = (rand_below(2) != 0);
      st = (rand_below(2) != 0);
      if (en) begin
        va = {l1_idx[rand_below(4)], l0_idx[rand_below(4)], 12'(rand_below(4096))};
      end else begin
        va = mmu_cfg_pkg::vaddr_t'($random(seed));
      end
      predict(va, st, priv, sum, en, exp_paddr, exp_fault, exp_reads);
      translation_en_i <= en;
      priv_i           <= priv;
      sum_i            <= sum;
      req_store_i      <= st;
      req_vaddr_i      <= va;
      req_v_i          <= 1'b1;
      @(posedge clk_i);
      if (req_ready_o !== 1'b1) begin
        fail_run("the DUT was not ready to accept a new request");
      end
      req_v_i <= 1'b0;
      reads0 = mem_reads;
      lat = 0;
      do begin
        @(posedge clk_i);
        lat++;
        if (req_ready_o !== 1'b0) begin
          fail_run("req_ready_o went high while a request was still outstanding");
        end
      end while (resp_v_o !== 1'b1);
      check_paddr(exp_paddr, resp_paddr_o);
      check_fault(exp_fault, resp_fault_o);
      check_count("mem_req_v_o reads", exp_reads, mem_reads - reads0);
      // Bypass and TLB hits answer on a fixed schedule
      if (exp_reads == 0) begin
        check_count("resp_v_o latency", 2, lat);
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+test
verilog/mmu_cfg_pkg.sv
verilog/pte_pkg.sv
verilog/dtlb.sv
verilog/ptw_fsm.sv
verilog/pte_addr_gen.sv
verilog/access_check.sv
verilog/mmu_top.sv
test/tb_mmu.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the MMU testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu \
  -f list.f -o sim_mmu &&
./obj_dir/sim_mmu || exit 1
